//--- sim.f
+incdir+hdl
hdl/wfd_pkg.sv
hdl/trigger_manager.sv
hdl/trig_num_fifo.sv
hdl/channel_rx_arbiter.sv
hdl/event_builder.sv
hdl/wfd_top.sv
dv/wfd_props.sv
dv/wfd_tb.sv

//--- Makefile
# Verilator build and run of the readout path testbench
SIM      := verilator
TOP      := wfd_tb
FILELIST := sim.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
PASS_MSG := Verification passed

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/wfd_tb.sv
// testbench for the readout path with channel and DAQ models, a packing reference and directed tests
`timescale 1ns/1ps
`default_nettype none

`include "wfd_params.svh"

module wfd_tb;

    import wfd_pkg::*;

    localparam int MAX_CYCLES = 4000;  // six tests of roughly 40 to 150 cycles each with wide margin
    localparam int MEM_DEPTH  = 64;    // per channel word store used as a ring

    logic                            clk;
    logic                            reset;
    logic                            trigger;
    chan_mask_t                      acq_trigs;
    chan_mask_t                      acq_dones;
    chan_mask_t                      c_rx_tvalid;
    chan_word_t [`WFD_NUM_CHAN-1:0]  c_rx_tdata;
    chan_mask_t                      c_rx_tlast;
    chan_mask_t                      c_rx_tready;
    logic                            daq_valid;
    logic                            daq_header;
    logic                            daq_trailer;
    daq_word_t                       daq_data;
    logic                            daq_ready;

    // channel model
    chan_word_t chan_mem [`WFD_NUM_CHAN][MEM_DEPTH];
    logic       chan_last_mem [`WFD_NUM_CHAN][MEM_DEPTH];
    int         chan_len [`WFD_NUM_CHAN];   // words queued so far
    int         chan_pos [`WFD_NUM_CHAN];   // words taken by the arbiter
    chan_mask_t chan_en;                    // channels allowed to show valid
    int         pkt_len [`WFD_NUM_CHAN];
    int         pkt_order [`WFD_NUM_CHAN];  // expected arrival order

    // DAQ sink and reference
    logic        rand_ready;
    logic [31:0] lfsr;
    logic [65:0] got_q [$];   // {header, trailer, data}
    logic [65:0] exp_q [$];
    int          got_rd;      // first word not yet compared
    int          last_tn;     // number of the last accepted trigger
    int          test_errs;
    int          total_errs;
    int          n_pass;
    int          n_fail;
    int          cycles;

    wfd_top i_dut (
        .clk(clk), .reset(reset),
        .trigger(trigger), .acq_trigs(acq_trigs), .acq_dones(acq_dones),
        .c_rx_tvalid(c_rx_tvalid), .c_rx_tdata(c_rx_tdata),
        .c_rx_tlast(c_rx_tlast), .c_rx_tready(c_rx_tready),
        .daq_valid(daq_valid), .daq_header(daq_header), .daq_trailer(daq_trailer),
        .daq_data(daq_data), .daq_ready(daq_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run stopped after %0d cycles", cycles);
        $display("Verification failed");
        $finish;
    end

    //////////////////////////////
    // helpers

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // channel, event and position all visible in the word
    function automatic chan_word_t word_value(input int ch, input int evt, input int w);
        return {8'(ch + 1), 8'(evt), 16'(w + 1)};
    endfunction

    function automatic void check_val(input string name, input string what,
                                      input logic [65:0] exp, input logic [65:0] act);
        if (act !== exp) begin
            $display("Fail %s: %s expected %0h actual %0h", name, what, exp, act);
            test_errs++;
        end
    endfunction

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            $display("%s: ok", name);
            n_pass++;
        end else begin
            $display("%s: %0d checks failed", name, test_errs);
            n_fail++;
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    // one cycle trigger with the pulse expected the cycle after it is sampled
    task automatic send_trigger(input string name, input logic accept);
        chan_mask_t want;
        want = accept ? '1 : '0;
        @(posedge clk);
        #1;
        trigger = 1'b1;
        @(negedge clk);
        check_val(name, "acq_trigs with trigger", '0, 66'(acq_trigs));
        @(posedge clk);
        #1;
        trigger = 1'b0;
        @(negedge clk);
        check_val(name, "acq_trigs after trigger", 66'(want), 66'(acq_trigs));
        @(negedge clk);
        check_val(name, "acq_trigs pulse end", '0, 66'(acq_trigs));
        if (accept) last_tn++;
    endtask

    task automatic send_dones();
        @(posedge clk);
        #1;
        acq_dones = '1;
        @(posedge clk);
        #1;
        acq_dones = '0;
    endtask

    // append one packet per channel with lengths from pkt_len
    task automatic load_packets(input int evt);
        int idx;
        @(negedge clk);
        for (int ch = 0; ch < `WFD_NUM_CHAN; ch++) begin
            for (int w = 0; w < pkt_len[ch]; w++) begin
                idx = (chan_len[ch] + w) % MEM_DEPTH;
                chan_mem[ch][idx]      = word_value(ch, evt, w);
                chan_last_mem[ch][idx] = (w == pkt_len[ch] - 1);
            end
            chan_len[ch] = chan_len[ch] + pkt_len[ch];
        end
    endtask

    task automatic wait_drained(input int ch);
        while (chan_pos[ch] != chan_len[ch]) @(posedge clk);
    endtask

    // reference event of header, packed pairs in pkt_order and trailer
    task automatic expect_event(input int tn);
        int         ch;
        int         words;
        chan_word_t lo;
        words = 0;
        exp_q.push_back({2'b10, `WFD_HDR_TAG, trig_num_t'(tn), 32'h0});
        for (int i = 0; i < `WFD_NUM_CHAN; i++) begin
            ch = pkt_order[i];
            for (int w = 0; w < pkt_len[ch]; w += 2) begin
                lo = (w + 1 < pkt_len[ch]) ? word_value(ch, tn, w + 1) : '0;  // odd tail pad
                exp_q.push_back({2'b00, word_value(ch, tn, w), lo});
                words++;
            end
        end
        // count covers header and trailer
        exp_q.push_back({2'b01, `WFD_TRL_TAG, trig_num_t'(tn), 12'h0, 20'(words + 2)});
    endtask

    task automatic compare_events(input string name);
        int n;
        n = exp_q.size();
        while (got_q.size() < got_rd + n) @(posedge clk);
        repeat (8) @(posedge clk);    // a repeated word would land here
        if (got_q.size() != got_rd + n) begin
            $display("Fail %s: word count expected %0d actual %0d",
                     name, n, got_q.size() - got_rd);
            test_errs++;
        end
        for (int i = 0; i < n; i++) begin
            check_val(name, $sformatf("word %0d", i), exp_q[i], got_q[got_rd + i]);
        end
        got_rd = got_q.size();
        exp_q.delete();
    endtask

    //////////////////////////////
    // channel and DAQ models

    initial begin
        chan_mask_t taken;
        int         idx;
        c_rx_tvalid = '0;
        c_rx_tdata  = '0;
        c_rx_tlast  = '0;
        for (int ch = 0; ch < `WFD_NUM_CHAN; ch++) chan_pos[ch] = 0;
        forever begin
            @(negedge clk);
            taken = c_rx_tvalid & c_rx_tready;   // settled here and moves on the coming edge
            @(posedge clk);
            #1;
            for (int ch = 0; ch < `WFD_NUM_CHAN; ch++) begin
                if (taken[ch]) chan_pos[ch] = chan_pos[ch] + 1;
                idx = chan_pos[ch] % MEM_DEPTH;
                c_rx_tvalid[ch] = chan_en[ch] && (chan_pos[ch] < chan_len[ch]);
                c_rx_tdata[ch]  = chan_mem[ch][idx];
                c_rx_tlast[ch]  = chan_last_mem[ch][idx];
            end
        end
    end

    initial begin
        daq_ready = 1'b0;
        lfsr      = 32'h94ea;
        forever begin
            @(negedge clk);
            if (daq_valid && daq_ready) begin
                got_q.push_back({daq_header, daq_trailer, daq_data.raw});
            end
            @(posedge clk);
            #1;
            if (rand_ready) begin
                lfsr      = lfsr_next(lfsr);   // one step per ready bit
                daq_ready = lfsr[0];
            end else begin
                daq_ready = 1'b1;
            end
        end
    end

    //////////////////////////////
    // directed tests

    task automatic reset_and_pulse();
        string name;
        name = "reset_and_pulse";
        @(negedge clk);
        check_val(name, "acq_trigs after reset", '0, 66'(acq_trigs));
        check_val(name, "daq_valid after reset", '0, 66'(daq_valid));
        check_val(name, "c_rx_tready after reset", '0, 66'(c_rx_tready));
        send_trigger(name, 1'b1);
        send_dones();
        pkt_len   = '{1, 1, 1, 1, 1};
        pkt_order = '{0, 1, 2, 3, 4};
        load_packets(last_tn);
        chan_en = '1;
        expect_event(last_tn);
        compare_events(name);
        finish_test(name);
    endtask

    task automatic retrigger_ignored();
        string name;
        name = "no_retrigger";
        send_trigger(name, 1'b1);
        send_trigger(name, 1'b0);    // dones still outstanding
        send_dones();
        pkt_len   = '{1, 2, 1, 2, 1};
        pkt_order = '{0, 1, 2, 3, 4};
        load_packets(last_tn);
        expect_event(last_tn);       // number 2 since the ignored one took none
        compare_events(name);
        finish_test(name);
    endtask

    task automatic packing(input string name, input logic random_ready);
        @(negedge clk);
        rand_ready = random_ready;
        send_trigger(name, 1'b1);
        send_dones();
        pkt_len   = '{3, 2, 1, 4, 2};
        pkt_order = '{0, 1, 2, 3, 4};
        load_packets(last_tn);
        expect_event(last_tn);
        compare_events(name);
        @(negedge clk);
        rand_ready = 1'b0;
        finish_test(name);
    endtask

    task automatic arrival_order();
        string name;
        name = "channel_order";
        @(negedge clk);
        chan_en = '0;
        send_trigger(name, 1'b1);
        send_dones();
        pkt_len   = '{2, 3, 1, 2, 1};
        pkt_order = '{3, 1, 4, 0, 2};
        load_packets(last_tn);
        for (int i = 0; i < `WFD_NUM_CHAN; i++) begin
            chan_en[pkt_order[i]] = 1'b1;   // one channel at a time
            wait_drained(pkt_order[i]);
            @(negedge clk);
        end
        expect_event(last_tn);
        compare_events(name);
        finish_test(name);
    endtask

    task automatic three_events();
        string name;
        int    first_tn;
        name     = "three_events";
        first_tn = last_tn + 1;
        for (int k = 0; k < 3; k++) begin
            send_trigger(name, 1'b1);
            send_dones();
            repeat (3) @(posedge clk);  // number reaches the FIFO
        end
        pkt_len   = '{2, 1, 3, 1, 2};
        pkt_order = '{0, 1, 2, 3, 4};
        for (int k = 0; k < 3; k++) begin
            load_packets(first_tn + k);
            expect_event(first_tn + k);
        end
        compare_events(name);
        finish_test(name);
    endtask

    initial begin
        reset      = 1'b1;
        trigger    = 1'b0;
        acq_dones  = '0;
        chan_en    = '0;
        rand_ready = 1'b0;
        got_rd     = 0;
        last_tn    = 0;
        test_errs  = 0;
        total_errs = 0;
        n_pass     = 0;
        n_fail     = 0;
        for (int ch = 0; ch < `WFD_NUM_CHAN; ch++) begin
            chan_len[ch]  = 0;
            pkt_len[ch]   = 0;
            pkt_order[ch] = ch;
            for (int d = 0; d < MEM_DEPTH; d++) begin
                chan_mem[ch][d]      = '0;
                chan_last_mem[ch][d] = 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // all channels valid together start at channel 0 while the pointer rests there
        reset_and_pulse();
        retrigger_ignored();
        packing("packing", 1'b0);
        packing("random_ready", 1'b1);
        three_events();
        arrival_order();   // last, it leaves the round-robin pointer on channel 3

        $display("Tests run 6, passed %0d, failed %0d, failed checks %0d",
                 n_pass, n_fail, total_errs);
        if (n_fail == 0 && total_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/wfd_props.sv
// protocol checks on the readout top level, bound into wfd_top
`timescale 1ns/1ps
`default_nettype none

`include "wfd_params.svh"

module wfd_props (
    input  logic                  clk,
    input  logic                  reset,
    input  wfd_pkg::chan_mask_t   acq_trigs,
    input  wfd_pkg::chan_mask_t   c_rx_tready,
    input  logic                  daq_valid,
    input  logic                  daq_header,
    input  logic                  daq_trailer,
    input  wfd_pkg::daq_word_t    daq_data,
    input  logic                  daq_ready
);

    // fan-out pulse never stretches
    a_trig_pulse: assert property (@(posedge clk) disable iff (reset)
        (|acq_trigs) |=> !(|acq_trigs))
        else $error("acq_trigs high for more than one cycle");

    // stalled link word holds still
    a_daq_hold: assert property (@(posedge clk) disable iff (reset)
        (daq_valid && !daq_ready) |=> (daq_valid && $stable(daq_data)
            && $stable(daq_header) && $stable(daq_trailer)))
        else $error("DAQ word changed while stalled");

    a_hdr_trl: assert property (@(posedge clk) disable iff (reset)
        !(daq_header && daq_trailer))
        else $error("header and trailer strobes high together");

    a_ready_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(c_rx_tready))
        else $error("more than one channel ready");

endmodule

bind wfd_top wfd_props i_props (
    .clk(clk), .reset(reset),
    .acq_trigs(acq_trigs), .c_rx_tready(c_rx_tready),
    .daq_valid(daq_valid), .daq_header(daq_header), .daq_trailer(daq_trailer),
    .daq_data(daq_data), .daq_ready(daq_ready)
);

`default_nettype wire

//--- hdl/wfd_top.sv
// master FPGA readout top: trigger manager, trigger number FIFO, rx arbiter, event builder
`timescale 1ns/1ps
`default_nettype none

`include "wfd_params.svh"

module wfd_top (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        trigger,      // front panel trigger
    output wfd_pkg::chan_mask_t                         acq_trigs,    // to channel FPGAs
    input  wfd_pkg::chan_mask_t                         acq_dones,    // from channel FPGAs
    // channel data streams
    input  wfd_pkg::chan_mask_t                         c_rx_tvalid,
    input  wfd_pkg::chan_word_t [`WFD_NUM_CHAN-1:0]     c_rx_tdata,
    input  wfd_pkg::chan_mask_t                         c_rx_tlast,
    output wfd_pkg::chan_mask_t                         c_rx_tready,
    // AMC13 DAQ link
    output logic                                        daq_valid,
    output logic                                        daq_header,
    output logic                                        daq_trailer,
    output wfd_pkg::daq_word_t                          daq_data,
    input  logic                                        daq_ready
);

    import wfd_pkg::*;

    // manager to FIFO
    logic       tm_tn_valid, tm_tn_ready;
    trig_num_t  tm_tn_data;
    // FIFO to builder
    logic       eb_tn_valid, eb_tn_ready;
    trig_num_t  eb_tn_data;
    // arbiter to builder
    logic       m_valid, m_last, m_ready;
    chan_word_t m_data;

    trigger_manager i_tm (
        .clk(clk), .reset(reset),
        .trigger(trigger),
        .acq_dones(acq_dones),
        .tn_ready(tm_tn_ready),
        .acq_trigs(acq_trigs),
        .tn_valid(tm_tn_valid),
        .tn_data(tm_tn_data)
    );

    trig_num_fifo i_fifo (
        .clk(clk), .reset(reset),
        .s_valid(tm_tn_valid), .s_data(tm_tn_data), .s_ready(tm_tn_ready),
        .m_valid(eb_tn_valid), .m_data(eb_tn_data), .m_ready(eb_tn_ready)
    );

    channel_rx_arbiter i_arb (
        .clk(clk), .reset(reset),
        .c_rx_tvalid(c_rx_tvalid), .c_rx_tdata(c_rx_tdata),
        .c_rx_tlast(c_rx_tlast),   .c_rx_tready(c_rx_tready),
        .m_valid(m_valid), .m_data(m_data), .m_last(m_last), .m_ready(m_ready)
    );

    event_builder i_eb (
        .clk(clk), .reset(reset),
        .tn_valid(eb_tn_valid), .tn_data(eb_tn_data), .tn_ready(eb_tn_ready),
        .m_valid(m_valid), .m_data(m_data), .m_last(m_last), .m_ready(m_ready),
        .daq_valid(daq_valid), .daq_header(daq_header), .daq_trailer(daq_trailer),
        .daq_data(daq_data), .daq_ready(daq_ready)
    );

endmodule

`default_nettype wire

//--- hdl/event_builder.sv
// event builder: one trigger number plus one packet per channel into DAQ link words
`timescale 1ns/1ps
`default_nettype none

`include "wfd_params.svh"

module event_builder (
    input  logic                  clk,
    input  logic                  reset,
    // trigger numbers
    input  logic                  tn_valid,
    input  wfd_pkg::trig_num_t    tn_data,
    output logic                  tn_ready,
    // merged channel stream
    input  logic                  m_valid,
    input  wfd_pkg::chan_word_t   m_data,
    input  logic                  m_last,
    output logic                  m_ready,
    // AMC13 DAQ link
    output logic                  daq_valid,
    output logic                  daq_header,
    output logic                  daq_trailer,
    output wfd_pkg::daq_word_t    daq_data,
    input  logic                  daq_ready
);

    import wfd_pkg::*;

    typedef enum logic [1:0] {
        EB_IDLE,     // pop a trigger number
        EB_HEADER,   // place the header word
        EB_GATHER,   // pack channel packets
        EB_TRAILER   // place the trailer word
    } eb_state_t;

    eb_state_t   state;
    trig_num_t   trig_num_q;   // number of the event being built
    chan_word_t  half_q;       // upper half waiting for its partner
    logic        half_valid;
    chan_idx_t   pkt_cnt;      // packets finished in this event
    logic [19:0] word_cnt;     // link words placed so far, header included
    logic        out_free;     // output register can take a word this cycle
    logic        m_xfer;
    logic        hdr_load;
    logic        pair_emit;
    logic        trl_load;
    logic        emit;
    daq_word_t   next_word;

    //////////////////////////////
    // handshakes
    assign out_free  = !daq_valid || daq_ready;
    assign tn_ready  = (state == EB_IDLE);
    assign m_ready   = (state == EB_GATHER) && out_free;   // stalls with the link
    assign m_xfer    = m_valid && m_ready;
    assign hdr_load  = (state == EB_HEADER) && out_free;
    assign pair_emit = m_xfer && (half_valid || m_last);   // full pair or odd tail
    assign trl_load  = (state == EB_TRAILER) && out_free;
    assign emit      = hdr_load || pair_emit || trl_load;

    // next link word, one of the three views
    always_comb begin
        next_word = '0;
        if (hdr_load) begin
            next_word.hdr.tag      = `WFD_HDR_TAG;
            next_word.hdr.trig_num = trig_num_q;
        end else if (trl_load) begin
            next_word.trl.tag      = `WFD_TRL_TAG;
            next_word.trl.trig_num = trig_num_q;
            next_word.trl.word_cnt = word_cnt + 1'b1;  // counts itself
        end else if (half_valid) begin
            next_word.raw = {half_q, m_data};            // first word on top
        end else begin
            next_word.raw = {m_data, {`WFD_CHAN_W{1'b0}}}; // lone last word, zero pad
        end
    end

    //////////////////////////////
    // payload
    always_ff @(posedge clk) begin
        if (emit) begin
            daq_data <= next_word;
        end
        if (m_xfer && !half_valid && !m_last) begin
            half_q <= m_data;
        end
        if (tn_valid && tn_ready) begin
            trig_num_q <= tn_data;
        end
    end

    //////////////////////////////
    // control
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= EB_IDLE;
            half_valid  <= 1'b0;
            pkt_cnt     <= '0;
            word_cnt    <= '0;
            daq_valid   <= 1'b0;
            daq_header  <= 1'b0;
            daq_trailer <= 1'b0;
        end else begin
            // word taken by the link, slot empties unless refilled below
            if (daq_valid && daq_ready) begin
                daq_valid   <= 1'b0;
                daq_header  <= 1'b0;
                daq_trailer <= 1'b0;
            end
            if (emit) begin
                daq_valid   <= 1'b1;
                daq_header  <= hdr_load;
                daq_trailer <= trl_load;
            end
            if (m_xfer) begin
                half_valid <= !half_valid && !m_last;   // pair resets at packet end
            end
            case (state)
                EB_IDLE: begin
                    if (tn_valid) begin
                        state <= EB_HEADER;
                    end
                end
                EB_HEADER: begin
                    if (hdr_load) begin
                        state    <= EB_GATHER;
                        word_cnt <= 20'd1;
                        pkt_cnt  <= '0;
                    end
                end
                EB_GATHER: begin
                    if (pair_emit) word_cnt <= word_cnt + 1'b1;
                    if (m_xfer && m_last) begin
                        pkt_cnt <= pkt_cnt + 1'b1;
                        if (pkt_cnt == chan_idx_t'(`WFD_NUM_CHAN - 1)) begin
                            state <= EB_TRAILER;   // every channel delivered
                        end
                    end
                end
                EB_TRAILER: begin
                    if (trl_load) begin
                        state <= EB_IDLE;
                    end
                end
                default: state <= EB_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/channel_rx_arbiter.sv
// round-robin merge of the channel streams, grant held for a whole packet
`timescale 1ns/1ps
`default_nettype none

`include "wfd_params.svh"

module channel_rx_arbiter (
    input  logic                                        clk,
    input  logic                                        reset,
    input  wfd_pkg::chan_mask_t                         c_rx_tvalid,
    input  wfd_pkg::chan_word_t [`WFD_NUM_CHAN-1:0]     c_rx_tdata,
    input  wfd_pkg::chan_mask_t                         c_rx_tlast,
    output wfd_pkg::chan_mask_t                         c_rx_tready,  // only granted channel
    output logic                                        m_valid,
    output wfd_pkg::chan_word_t                         m_data,
    output logic                                        m_last,
    input  logic                                        m_ready
);

    import wfd_pkg::*;

    chan_idx_t  ptr;         // search starts here
    chan_idx_t  grant_q;     // locked channel
    logic       locked;      // packet in progress
    chan_idx_t  search_idx;
    chan_idx_t  cur_idx;
    logic       m_xfer;

    // wrap to channel 0 after the last one
    function automatic chan_idx_t next_chan(input chan_idx_t c);
        return (c == chan_idx_t'(`WFD_NUM_CHAN - 1)) ? '0 : c + 1'b1;
    endfunction

    //////////////////////////////
    // round-robin search
    always_comb begin
        int k;
        search_idx = ptr;   // nobody valid, harmless default
        // walk down so the closest valid channel at or after ptr wins
        for (int i = `WFD_NUM_CHAN - 1; i >= 0; i--) begin
            k = int'(ptr) + i;
            if (k >= `WFD_NUM_CHAN) k = k - `WFD_NUM_CHAN;
            if (c_rx_tvalid[k]) search_idx = chan_idx_t'(k);
        end
    end

    //////////////////////////////
    // steering
    assign cur_idx = locked ? grant_q : search_idx;
    assign m_valid = c_rx_tvalid[cur_idx];
    assign m_data  = c_rx_tdata[cur_idx];
    assign m_last  = c_rx_tlast[cur_idx];
    assign m_xfer  = m_valid && m_ready;

    always_comb begin
        c_rx_tready = '0;
        if (m_ready && (locked || (|c_rx_tvalid))) begin
            c_rx_tready[cur_idx] = 1'b1;   // ready goes back to the chosen source only
        end
    end

    // grant is taken as soon as a channel shows valid, so the merged
    // stream never switches source under a pending word
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr     <= '0;
            grant_q <= '0;
            locked  <= 1'b0;
        end else if (m_xfer && m_last) begin
            locked <= 1'b0;
            ptr    <= next_chan(cur_idx);   // packet done, move on
        end else if (!locked && m_valid) begin
            locked  <= 1'b1;
            grant_q <= cur_idx;
        end
    end

endmodule

`default_nettype wire

//--- hdl/trig_num_fifo.sv
// small synchronous FIFO holding trigger numbers between the manager and the builder
`timescale 1ns/1ps
`default_nettype none

`include "wfd_params.svh"

module trig_num_fifo #(
    parameter int DEPTH = `WFD_FIFO_DEPTH   // power of two
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 s_valid,
    input  wfd_pkg::trig_num_t   s_data,
    output logic                 s_ready,   // low when full
    output logic                 m_valid,   // low when empty
    input  logic                 m_ready,
    output wfd_pkg::trig_num_t   m_data
);

    import wfd_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    trig_num_t      mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;     // occupancy, 0..DEPTH
    logic           push;
    logic           pop;

    assign s_ready = (count != (AW+1)'(DEPTH));
    assign m_valid = (count != '0);
    assign m_data  = mem[rd_ptr];   // head entry, visible the cycle after write
    assign push    = s_valid && s_ready;
    assign pop     = m_valid && m_ready;

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= s_data;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/trigger_manager.sv
// trigger manager: fans triggers out to the channels, collects dones, numbers triggers
`timescale 1ns/1ps
`default_nettype none

`include "wfd_params.svh"

module trigger_manager (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  trigger,     // accepted only while idle
    input  wfd_pkg::chan_mask_t   acq_dones,   // done pulses from the channels
    input  logic                  tn_ready,    // trigger number FIFO has room
    output wfd_pkg::chan_mask_t   acq_trigs,   // one cycle go to every channel
    output logic                  tn_valid,
    output wfd_pkg::trig_num_t    tn_data
);

    import wfd_pkg::*;

    typedef enum logic [1:0] {
        TM_IDLE,    // waiting for a trigger
        TM_WAIT,    // channels acquiring, gathering dones
        TM_PUSH     // offering the trigger number to the FIFO
    } tm_state_t;

    tm_state_t  state;
    chan_mask_t done_mask;   // dones seen so far for this trigger
    logic       accept;
    logic       all_done;

    assign accept   = (state == TM_IDLE) && trigger;
    assign all_done = &(done_mask | acq_dones);    // a pulse this cycle counts too
    assign tn_valid = (state == TM_PUSH);           // held until the FIFO takes it

    //////////////////////////////
    // control
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= TM_IDLE;
            acq_trigs <= '0;
            done_mask <= '0;
            tn_data   <= '0;    // first accepted trigger becomes number 1
        end else begin
            acq_trigs <= accept ? '1 : '0;  // single cycle pulse after the trigger
            case (state)
                TM_IDLE: begin
                    if (accept) begin
                        state     <= TM_WAIT;
                        done_mask <= '0;
                        tn_data   <= tn_data + 1'b1;
                    end
                end
                TM_WAIT: begin
                    done_mask <= done_mask | acq_dones;  // latch each pulse
                    if (all_done) begin
                        state <= TM_PUSH;
                    end
                end
                TM_PUSH: begin
                    // triggers stay ignored until the number is in the FIFO
                    if (tn_ready) begin
                        state <= TM_IDLE;
                    end
                end
                default: state <= TM_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/wfd_pkg.sv
// types shared by the trigger and readout path of the master FPGA
`default_nettype none

`include "wfd_params.svh"

package wfd_pkg;

    typedef logic [`WFD_CHAN_W-1:0]     chan_word_t;  // one channel stream word
    typedef logic [`WFD_NUM_CHAN-1:0]   chan_mask_t;  // one bit per channel
    typedef logic [2:0]                 chan_idx_t;   // channel number 0..4
    typedef logic [`WFD_TRIG_NUM_W-1:0] trig_num_t;   // trigger number

    // first word of an event
    typedef struct packed {
        logic [7:0]  tag;       // WFD_HDR_TAG
        trig_num_t   trig_num;
        logic [31:0] zero;
    } daq_hdr_t;

    // last word of an event, count covers header and trailer too
    typedef struct packed {
        logic [7:0]  tag;       // WFD_TRL_TAG
        trig_num_t   trig_num;
        logic [11:0] zero;
        logic [19:0] word_cnt;
    } daq_trl_t;

    // the header / trailer strobes pick which view is meaningful
    typedef union packed {
        daq_hdr_t                hdr;
        daq_trl_t                trl;
        logic [`WFD_DAQ_W-1:0]   raw;   // data words
    } daq_word_t;

endpackage

`default_nettype wire

//--- hdl/wfd_params.svh
// shared sizes and word tags for the master FPGA trigger and readout path
`ifndef WFD_PARAMS_SVH
`define WFD_PARAMS_SVH

// channel side
`define WFD_NUM_CHAN    5       // channel FPGAs on the board
`define WFD_CHAN_W      32      // one channel stream word

// DAQ link side
`define WFD_DAQ_W       64      // one AMC13 link word
`define WFD_TRIG_NUM_W  24      // trigger number carried in header and trailer

// trigger number buffering between manager and builder
`define WFD_FIFO_DEPTH  4       // power of two

// tags in the top byte of header and trailer words
`define WFD_HDR_TAG     8'hA5
`define WFD_TRL_TAG     8'h5A

`endif
